/* common/vexec_pkg.sv */
/*
  Shared definitions for the two-lane vector execute stage.
  Holds the element and field widths, and the encodings for the
  operand source, functional unit, ALU op and stride source.
  RTL modules import it inside their bodies and use scoped names
  in their port lists.
*/
`default_nettype none

package vexec_pkg;

  // Element, scalar register and address width
  localparam int DATA_W = 32;
  localparam int VL_W   = 8;
  localparam int WOFF_W = 8;
  // Scalar register index
  localparam int RSEL_W = 5;

  typedef enum logic [1:0] {
    V    = 2'd0,
    I    = 2'd1,
    X    = 2'd2,
    NONE = 2'd3
  } operand_src_t;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_LS  = 1'b1
  } fu_type_t;

  // Shifts take operand 2 as the value and operand 1 as the amount
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLL   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    MINU  = 4'd8,
    MAXU  = 4'd9,
    MIN   = 4'd10,
    MAX   = 4'd11,
    MERGE = 4'd12
  } aluop_t;

  typedef enum logic {
    UNIT    = 1'b0,
    STRIDED = 1'b1
  } stride_src_t;

endpackage

`default_nettype wire

/* vector_lane/vector_lane.sv */
/*
  One element lane of the vector execute stage.
  Purely combinational. Runs the masked integer ALU op on the two
  selected operands and forms the element address pair used by
  unit-stride, constant-stride and indexed loads and stores.
*/
`timescale 1ns/10ps
`default_nettype none

module vector_lane (
  input  logic [vexec_pkg::DATA_W-1:0] vs1_data,
  input  logic [vexec_pkg::DATA_W-1:0] vs2_data,
  input  vexec_pkg::aluop_t            aluop,
  input  logic                         mask,
  input  logic [vexec_pkg::DATA_W-1:0] porta,
  input  logic [vexec_pkg::DATA_W-1:0] stride,
  input  logic [vexec_pkg::DATA_W-1:0] index,
  input  logic                         ls_idx,
  output logic [vexec_pkg::DATA_W-1:0] lane_result,
  output logic [vexec_pkg::DATA_W-1:0] in_addr,
  output logic [vexec_pkg::DATA_W-1:0] out_addr
);

  import vexec_pkg::*;

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [DATA_W-1:0]  alu_a;
  logic [DATA_W-1:0]  alu_b;
  logic [DATA_W-1:0]  alu_out;
  logic [SHAMT_W-1:0] shamt;
  logic               is_shift;
  logic               lt_u;
  logic               lt_s;
  logic [DATA_W-1:0]  idx_addr;

  // Shifts swap the operands
  assign is_shift = (aluop == SLL) || (aluop == SRL) || (aluop == SRA);
  assign alu_a    = is_shift ? vs2_data : vs1_data;
  assign alu_b    = is_shift ? vs1_data : vs2_data;
  assign shamt    = alu_b[SHAMT_W-1:0];

  assign lt_u = alu_a < alu_b;
  assign lt_s = $signed(alu_a) < $signed(alu_b);

  always_comb begin
    case (aluop)
      ADD:     alu_out = alu_a + alu_b;
      SUB:     alu_out = alu_a - alu_b;
      AND:     alu_out = alu_a & alu_b;
      OR:      alu_out = alu_a | alu_b;
      XOR:     alu_out = alu_a ^ alu_b;
      SLL:     alu_out = alu_a << shamt;
      SRL:     alu_out = alu_a >> shamt;
      SRA:     alu_out = DATA_W'($signed(alu_a) >>> shamt);
      MINU:    alu_out = lt_u ? alu_a : alu_b;
      MAXU:    alu_out = lt_u ? alu_b : alu_a;
      MIN:     alu_out = lt_s ? alu_a : alu_b;
      MAX:     alu_out = lt_s ? alu_b : alu_a;
      MERGE:   alu_out = mask ? vs1_data : vs2_data;
      default: alu_out = '0;
    endcase
  end

  // Inactive element keeps operand 2, except merge which uses the mask itself
  always_comb begin
    if (!mask && (aluop != MERGE)) begin
      lane_result = vs2_data;
    end else begin
      lane_result = alu_out;
    end
  end

  // Indexed access gives the same address on both ports
  assign idx_addr = porta + index;

  always_comb begin
    if (ls_idx) begin
      in_addr  = idx_addr;
      out_addr = idx_addr;
    end else begin
      in_addr  = porta;
      out_addr = porta + stride;
    end
  end

endmodule

`default_nettype wire

/* execute/vexec_stage.sv */
/*
  Execute stage of the two-lane vector pipeline.
  Selects lane operands from V, I or X sources, chains element
  addresses across both lanes and across beats through a carried
  address register, and latches results for the memory stage.
  Stall holds the latch, flush clears it and wins over stall.
  The scalar write-back port is combinational.
*/
`timescale 1ns/10ps
`default_nettype none

module vexec_stage (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            stall_ex,
  input  logic                            flush_ex,
  input  logic                            load,
  input  logic                            store,
  input  vexec_pkg::fu_type_t             fu_type,
  input  vexec_pkg::aluop_t               aluop,
  input  vexec_pkg::operand_src_t         rs1_type,
  input  vexec_pkg::operand_src_t         rs2_type,
  input  vexec_pkg::stride_src_t          stride_type,
  input  logic                            ls_idx,
  input  logic [vexec_pkg::DATA_W-1:0]    stride_val, imm, xs1, xs2,
  input  logic [vexec_pkg::DATA_W-1:0]    vs1_lane0, vs1_lane1,
  input  logic [vexec_pkg::DATA_W-1:0]    vs2_lane0, vs2_lane1,
  input  logic [vexec_pkg::DATA_W-1:0]    storedata0, storedata1,
  input  logic                            mask0, mask1,
  input  logic                            wen0, wen1,
  input  logic [vexec_pkg::WOFF_W-1:0]    woffset0, woffset1,
  input  logic                            config_type,
  input  logic [vexec_pkg::VL_W-1:0]      vl,
  input  logic [vexec_pkg::DATA_W-1:0]    vtype,
  input  logic                            rd_wen_in,
  input  logic [vexec_pkg::RSEL_W-1:0]    rd_sel_in,
  output logic                            mem_load, mem_store,
  output logic [vexec_pkg::DATA_W-1:0]    mem_storedata0, mem_storedata1,
  output logic [vexec_pkg::DATA_W-1:0]    mem_result0, mem_result1,
  output logic                            mem_wen0, mem_wen1,
  output logic [vexec_pkg::WOFF_W-1:0]    mem_woffset0, mem_woffset1,
  output logic                            mem_config_type,
  output logic [vexec_pkg::VL_W-1:0]      mem_vl,
  output logic [vexec_pkg::DATA_W-1:0]    mem_vtype,
  output logic                            rd_wen,
  output logic [vexec_pkg::RSEL_W-1:0]    rd_sel,
  output logic [vexec_pkg::DATA_W-1:0]    rd_data
);

  import vexec_pkg::*;

  logic [DATA_W-1:0] op1_l0, op1_l1, op2_l0, op2_l1;
  logic [DATA_W-1:0] stride, start_addr, porta_l0, porta_l1;
  logic [DATA_W-1:0] result_l0, result_l1;
  logic [DATA_W-1:0] in_addr_l0, in_addr_l1, out_addr_l0, out_addr_l1;
  logic [DATA_W-1:0] addr_reg, addr_next;
  logic              ls;

  // Operand 1 source
  always_comb begin
    case (rs1_type)
      V:       {op1_l0, op1_l1} = {vs1_lane0, vs1_lane1};
      I:       {op1_l0, op1_l1} = {imm, imm};
      X:       {op1_l0, op1_l1} = {xs1, xs1};
      default: {op1_l0, op1_l1} = '0;
    endcase
  end

  // Operand 2 source
  always_comb begin
    case (rs2_type)
      V:       {op2_l0, op2_l1} = {vs2_lane0, vs2_lane1};
      I:       {op2_l0, op2_l1} = {imm, imm};
      X:       {op2_l0, op2_l1} = {xs2, xs2};
      default: {op2_l0, op2_l1} = '0;
    endcase
  end

  assign stride = (stride_type == STRIDED) ? stride_val : DATA_W'(4);

  // New chain at element 0, else continue from the previous beat
  assign start_addr = (woffset0 == '0) ? xs1 : addr_reg;
  assign porta_l0   = ls_idx ? xs1 : start_addr;
  assign porta_l1   = ls_idx ? xs1 : out_addr_l0;

  vector_lane lane0 (
    .vs1_data(op1_l0), .vs2_data(op2_l0), .aluop(aluop), .mask(mask0),
    .porta(porta_l0), .stride(stride), .index(vs2_lane0), .ls_idx(ls_idx),
    .lane_result(result_l0), .in_addr(in_addr_l0), .out_addr(out_addr_l0)
  );

  vector_lane lane1 (
    .vs1_data(op1_l1), .vs2_data(op2_l1), .aluop(aluop), .mask(mask1),
    .porta(porta_l1), .stride(stride), .index(vs2_lane1), .ls_idx(ls_idx),
    .lane_result(result_l1), .in_addr(in_addr_l1), .out_addr(out_addr_l1)
  );

  // Carried address is start plus two strides, also in indexed mode
  assign addr_next = ls_idx ? start_addr + (stride << 1) : out_addr_l1;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_reg <= '0;
    end else if (!stall_ex) begin
      addr_reg <= addr_next;
    end
  end

  assign ls = (fu_type == FU_LS) || load || store;

  // Execute to memory latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mem_load        <= 1'b0;
      mem_store       <= 1'b0;
      mem_storedata0  <= '0;
      mem_storedata1  <= '0;
      mem_result0     <= '0;
      mem_result1     <= '0;
      mem_wen0        <= 1'b0;
      mem_wen1        <= 1'b0;
      mem_woffset0    <= '0;
      mem_woffset1    <= '0;
      mem_config_type <= 1'b0;
      mem_vl          <= '0;
      mem_vtype       <= '0;
    end else if (flush_ex) begin
      mem_load        <= 1'b0;
      mem_store       <= 1'b0;
      mem_storedata0  <= '0;
      mem_storedata1  <= '0;
      mem_result0     <= '0;
      mem_result1     <= '0;
      mem_wen0        <= 1'b0;
      mem_wen1        <= 1'b0;
      mem_woffset0    <= '0;
      mem_woffset1    <= '0;
      mem_config_type <= 1'b0;
      mem_vl          <= '0;
      mem_vtype       <= '0;
    end else if (!stall_ex) begin
      mem_load        <= load;
      mem_store       <= store;
      mem_storedata0  <= storedata0;
      mem_storedata1  <= storedata1;
      // Lane 1 in_addr is start + stride when strided, xs1 + index when indexed
      mem_result0     <= ls ? in_addr_l0 : result_l0;
      mem_result1     <= ls ? in_addr_l1 : result_l1;
      mem_wen0        <= wen0;
      mem_wen1        <= wen1;
      mem_woffset0    <= woffset0;
      mem_woffset1    <= woffset1;
      mem_config_type <= config_type;
      mem_vl          <= vl;
      mem_vtype       <= vtype;
    end
  end

  // Scalar write-back, same cycle
  assign rd_wen  = rd_wen_in | config_type;
  assign rd_sel  = rd_sel_in;
  assign rd_data = config_type ? {{(DATA_W-VL_W){1'b0}}, vl} : result_l0;

endmodule

`default_nettype wire

/* verilog/vexec_top.sv */
/*
  Top level of the vector execute stage.
  Exposes the decode, hazard and memory-stage signals as ports so a
  testbench can drive and observe them, and wraps one stage instance.
*/
`timescale 1ns/10ps
`default_nettype none

module vexec_top (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            stall_ex,
  input  logic                            flush_ex,
  input  logic                            load,
  input  logic                            store,
  input  vexec_pkg::fu_type_t             fu_type,
  input  vexec_pkg::aluop_t               aluop,
  input  vexec_pkg::operand_src_t         rs1_type,
  input  vexec_pkg::operand_src_t         rs2_type,
  input  vexec_pkg::stride_src_t          stride_type,
  input  logic                            ls_idx,
  input  logic [vexec_pkg::DATA_W-1:0]    stride_val, imm, xs1, xs2,
  input  logic [vexec_pkg::DATA_W-1:0]    vs1_lane0, vs1_lane1,
  input  logic [vexec_pkg::DATA_W-1:0]    vs2_lane0, vs2_lane1,
  input  logic [vexec_pkg::DATA_W-1:0]    storedata0, storedata1,
  input  logic                            mask0, mask1,
  input  logic                            wen0, wen1,
  input  logic [vexec_pkg::WOFF_W-1:0]    woffset0, woffset1,
  input  logic                            config_type,
  input  logic [vexec_pkg::VL_W-1:0]      vl,
  input  logic [vexec_pkg::DATA_W-1:0]    vtype,
  input  logic                            rd_wen_in,
  input  logic [vexec_pkg::RSEL_W-1:0]    rd_sel_in,
  output logic                            mem_load, mem_store,
  output logic [vexec_pkg::DATA_W-1:0]    mem_storedata0, mem_storedata1,
  output logic [vexec_pkg::DATA_W-1:0]    mem_result0, mem_result1,
  output logic                            mem_wen0, mem_wen1,
  output logic [vexec_pkg::WOFF_W-1:0]    mem_woffset0, mem_woffset1,
  output logic                            mem_config_type,
  output logic [vexec_pkg::VL_W-1:0]      mem_vl,
  output logic [vexec_pkg::DATA_W-1:0]    mem_vtype,
  output logic                            rd_wen,
  output logic [vexec_pkg::RSEL_W-1:0]    rd_sel,
  output logic [vexec_pkg::DATA_W-1:0]    rd_data
);

  // Port names match the stage one to one
  vexec_stage stage (.*);

endmodule

`default_nettype wire

/* verification/vexec_props.sv */
/*
  Assertions on the execute to memory latch, bound into the stage.
  Checks that all latched outputs are zero during reset, that a flush
  clears them on the next edge and that a stall holds them.
*/
`timescale 1ns/10ps
`default_nettype none

module vexec_props (
  input logic                         CLK, nRST, stall_ex, flush_ex,
  input logic                         mem_load, mem_store, mem_wen0, mem_wen1, mem_config_type,
  input logic [vexec_pkg::DATA_W-1:0] mem_storedata0, mem_storedata1, mem_vtype,
  input logic [vexec_pkg::DATA_W-1:0] mem_result0, mem_result1,
  input logic [vexec_pkg::WOFF_W-1:0] mem_woffset0, mem_woffset1,
  input logic [vexec_pkg::VL_W-1:0]   mem_vl
);

  import vexec_pkg::*;

  localparam int ALL_W = 5 + 5 * DATA_W + 2 * WOFF_W + VL_W;

  logic [ALL_W-1:0] mem_all;

  assign mem_all = {mem_load, mem_store, mem_wen0, mem_wen1, mem_config_type,
                    mem_storedata0, mem_storedata1, mem_vtype, mem_result0, mem_result1,
                    mem_woffset0, mem_woffset1, mem_vl};

  reset_clears: assert property (@(posedge CLK) !nRST |-> mem_all == '0)
    else $error("Memory stage outputs not zero during reset");

  // Flush wins over a stall in the same cycle
  flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush_ex |=> mem_all == '0)
    else $error("Memory stage outputs not cleared after flush");

  stall_holds: assert property (@(posedge CLK) disable iff (!nRST)
    (stall_ex && !flush_ex) |=> $stable(mem_all))
    else $error("Memory stage outputs changed during stall");

endmodule

`default_nettype wire

/* verification/vexec_checker.sv */
/*
  Result checker for the vector execute stage.
  Samples the decode inputs on every rising edge, keeps its own copy
  of the carried address register and predicts the latched mem_*
  values, which are compared one edge later. The scalar write-back
  port is compared at each edge against the inputs still applied.
*/
`timescale 1ns/10ps
`default_nettype none

module vexec_checker (
  input  logic                         CLK, nRST, stall_ex, flush_ex,
  input  logic                         load, store, ls_idx,
  input  vexec_pkg::fu_type_t          fu_type,
  input  vexec_pkg::aluop_t            aluop,
  input  vexec_pkg::operand_src_t      rs1_type, rs2_type,
  input  vexec_pkg::stride_src_t       stride_type,
  input  logic [vexec_pkg::DATA_W-1:0] stride_val, imm, xs1, xs2, vtype,
  input  logic [vexec_pkg::DATA_W-1:0] vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1,
  input  logic [vexec_pkg::DATA_W-1:0] storedata0, storedata1,
  input  logic                         mask0, mask1, wen0, wen1, config_type, rd_wen_in,
  input  logic [vexec_pkg::WOFF_W-1:0] woffset0, woffset1,
  input  logic [vexec_pkg::VL_W-1:0]   vl,
  input  logic [vexec_pkg::RSEL_W-1:0] rd_sel_in,
  input  logic                         mem_load, mem_store, mem_wen0, mem_wen1,
  input  logic                         mem_config_type, rd_wen,
  input  logic [vexec_pkg::DATA_W-1:0] mem_storedata0, mem_storedata1, mem_vtype,
  input  logic [vexec_pkg::DATA_W-1:0] mem_result0, mem_result1, rd_data,
  input  logic [vexec_pkg::WOFF_W-1:0] mem_woffset0, mem_woffset1,
  input  logic [vexec_pkg::VL_W-1:0]   mem_vl,
  input  logic [vexec_pkg::RSEL_W-1:0] rd_sel,
  output int                           err_count, check_count
);

  import vexec_pkg::*;

  logic              e_load, e_store, e_wen0, e_wen1, e_cfg;
  logic [DATA_W-1:0] e_sd0, e_sd1, e_res0, e_res1, e_vtype;
  logic [WOFF_W-1:0] e_woff0, e_woff1;
  logic [VL_W-1:0]   e_vl;
  logic [DATA_W-1:0] addr_model, stride_m, start;

  function automatic logic [DATA_W-1:0] pick_operand(operand_src_t src,
      logic [DATA_W-1:0] vreg, logic [DATA_W-1:0] imm_v, logic [DATA_W-1:0] xreg);
    logic [DATA_W-1:0] val;
    case (src)
      V:       val = vreg;
      I:       val = imm_v;
      X:       val = xreg;
      default: val = '0;
    endcase
    return val;
  endfunction

  // Shifts move operand 2 by the amount in operand 1
  function automatic logic [DATA_W-1:0] expected_lane(aluop_t op,
      logic [DATA_W-1:0] op1, logic [DATA_W-1:0] op2, logic m);
    logic [DATA_W-1:0] r;
    logic [4:0]        sh;
    sh = op1[4:0];
    case (op)
      ADD:     r = op1 + op2;
      SUB:     r = op1 - op2;
      AND:     r = op1 & op2;
      OR:      r = op1 | op2;
      XOR:     r = op1 ^ op2;
      SLL:     r = op2 << sh;
      SRL:     r = op2 >> sh;
      SRA:     r = $signed(op2) >>> sh;
      MINU:    r = (op1 < op2) ? op1 : op2;
      MAXU:    r = (op1 > op2) ? op1 : op2;
      MIN:     r = ($signed(op1) < $signed(op2)) ? op1 : op2;
      MAX:     r = ($signed(op1) > $signed(op2)) ? op1 : op2;
      MERGE:   r = m ? op1 : op2;
      default: r = '0;
    endcase
    if (!m && (op != MERGE)) begin
      r = op2;
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] got,
      input logic [DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic clear_expected();
    {e_load, e_store, e_wen0, e_wen1, e_cfg} = '0;
    {e_sd0, e_sd1, e_res0, e_res1, e_vtype, e_woff0, e_woff1, e_vl} = '0;
  endtask

  always @(posedge CLK) begin
    if (!nRST) begin
      clear_expected();
      addr_model  = '0;
      err_count   = 0;
      check_count = 0;
    end else begin
      compare("mem_load", DATA_W'(mem_load), DATA_W'(e_load));
      compare("mem_store", DATA_W'(mem_store), DATA_W'(e_store));
      compare("mem_storedata0", mem_storedata0, e_sd0);
      compare("mem_storedata1", mem_storedata1, e_sd1);
      compare("mem_result0", mem_result0, e_res0);
      compare("mem_result1", mem_result1, e_res1);
      compare("mem_wen0", DATA_W'(mem_wen0), DATA_W'(e_wen0));
      compare("mem_wen1", DATA_W'(mem_wen1), DATA_W'(e_wen1));
      compare("mem_woffset0", DATA_W'(mem_woffset0), DATA_W'(e_woff0));
      compare("mem_woffset1", DATA_W'(mem_woffset1), DATA_W'(e_woff1));
      compare("mem_config_type", DATA_W'(mem_config_type), DATA_W'(e_cfg));
      compare("mem_vl", DATA_W'(mem_vl), DATA_W'(e_vl));
      compare("mem_vtype", mem_vtype, e_vtype);
      // Scalar port has no latency and still shows the beat ending here
      compare("rd_wen", DATA_W'(rd_wen), DATA_W'(rd_wen_in | config_type));
      compare("rd_sel", DATA_W'(rd_sel), DATA_W'(rd_sel_in));
      compare("rd_data", rd_data, config_type ? DATA_W'(vl) :
              expected_lane(aluop, pick_operand(rs1_type, vs1_lane0, imm, xs1),
                            pick_operand(rs2_type, vs2_lane0, imm, xs2), mask0));
      stride_m = (stride_type == STRIDED) ? stride_val : DATA_W'(4);
      // Element 0 starts a fresh chain at xs1
      start = (woffset0 == '0) ? xs1 : addr_model;
      if (flush_ex) begin
        clear_expected();
      end else if (!stall_ex) begin
        {e_load, e_store, e_sd0, e_sd1} = {load, store, storedata0, storedata1};
        {e_wen0, e_wen1, e_woff0, e_woff1} = {wen0, wen1, woffset0, woffset1};
        {e_cfg, e_vl, e_vtype} = {config_type, vl, vtype};
        if ((fu_type == FU_LS) || load || store) begin
          e_res0 = ls_idx ? xs1 + vs2_lane0 : start;
          e_res1 = ls_idx ? xs1 + vs2_lane1 : start + stride_m;
        end else begin
          e_res0 = expected_lane(aluop, pick_operand(rs1_type, vs1_lane0, imm, xs1),
                                 pick_operand(rs2_type, vs2_lane0, imm, xs2), mask0);
          e_res1 = expected_lane(aluop, pick_operand(rs1_type, vs1_lane1, imm, xs1),
                                 pick_operand(rs2_type, vs2_lane1, imm, xs2), mask1);
        end
      end
      if (!stall_ex) begin
        addr_model = start + (stride_m << 1);
      end
    end
  end

endmodule

`default_nettype wire

/* verification/vexec_tb.sv */
/*
  Testbench top for the two-lane vector execute stage.
  Runs random ALU beats, strided and indexed address chains, then a
  mixed phase with random stalls and flushes. The checker compares
  every result; the run ends with an error count and a verdict.
*/
`timescale 1ns/10ps
`default_nettype none

module vexec_tb;

  import vexec_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_ALU      = 200;
  localparam int N_CHAIN    = 64;
  localparam int N_IDX      = 40;
  localparam int N_HAZ      = 150;
  localparam int N_BEATS    = N_ALU + N_CHAIN + N_IDX + N_HAZ;

  logic              CLK = 1'b0;
  logic              nRST, stall_ex, flush_ex, load, store, ls_idx;
  fu_type_t          fu_type;
  aluop_t            aluop;
  operand_src_t      rs1_type, rs2_type;
  stride_src_t       stride_type;
  logic [DATA_W-1:0] stride_val, imm, xs1, xs2, vtype, storedata0, storedata1;
  logic [DATA_W-1:0] vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1;
  logic              mask0, mask1, wen0, wen1, config_type, rd_wen_in;
  logic [WOFF_W-1:0] woffset0, woffset1, mem_woffset0, mem_woffset1;
  logic [VL_W-1:0]   vl, mem_vl;
  logic [RSEL_W-1:0] rd_sel_in, rd_sel;
  logic              mem_load, mem_store, mem_wen0, mem_wen1, mem_config_type, rd_wen;
  logic [DATA_W-1:0] mem_storedata0, mem_storedata1, mem_vtype;
  logic [DATA_W-1:0] mem_result0, mem_result1, rd_data;
  int                err_count, check_count;
  integer            seed = 32'h48240606;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  vexec_top vexec_top_inst (.*);
  vexec_checker result_check (.*);
  bind vexec_stage vexec_props stage_props (.*);

  // Mode 0 is an ALU beat, 1 a strided access, 2 an indexed access
  task automatic drive_beat(input int mode, input int woff, input bit hazards);
    int r;
    @(posedge CLK);
    r = $random(seed);
    load        <= (mode != 0) && r[0];
    store       <= (mode != 0) && !r[0];
    fu_type     <= (mode != 0) ? FU_LS : FU_ALU;
    ls_idx      <= (mode == 2);
    aluop       <= aluop_t'(4'($unsigned($random(seed)) % 13));
    rs1_type    <= operand_src_t'(r[2:1]);
    rs2_type    <= operand_src_t'(r[4:3]);
    stride_type <= stride_src_t'(r[5]);
    mask0       <= r[6];
    mask1       <= r[7];
    wen0        <= r[8];
    wen1        <= r[9];
    config_type <= (r[12:10] == 3'd0);
    rd_wen_in   <= r[13];
    rd_sel_in   <= r[18:14];
    stall_ex    <= hazards && (r[21:19] < 3'd2);
    flush_ex    <= hazards && (r[24:22] == 3'd0);
    vl          <= r[31:24];
    woffset0    <= WOFF_W'(woff);
    woffset1    <= WOFF_W'(woff + 1);
    stride_val  <= $random(seed);
    imm         <= $random(seed);
    xs1         <= $random(seed);
    xs2         <= $random(seed);
    vs1_lane0   <= $random(seed);
    vs1_lane1   <= $random(seed);
    vs2_lane0   <= $random(seed);
    vs2_lane1   <= $random(seed);
    storedata0  <= $random(seed);
    storedata1  <= $random(seed);
    vtype       <= $random(seed);
  endtask

  initial begin
    nRST = 1'b0;
    {stall_ex, flush_ex, load, store, ls_idx} = '0;
    fu_type     = FU_ALU;
    aluop       = ADD;
    rs1_type    = V;
    rs2_type    = V;
    stride_type = UNIT;
    {stride_val, imm, xs1, xs2, vtype, storedata0, storedata1} = '0;
    {vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1} = '0;
    {mask0, mask1, wen0, wen1, config_type, rd_wen_in} = '0;
    {woffset0, woffset1, vl, rd_sel_in} = '0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    for (int n = 0; n < N_ALU; n++) drive_beat(0, n, 1'b0);
    // Chains of eight beats, each opened by element offset 0
    for (int n = 0; n < N_CHAIN; n++) drive_beat(1, (n % 8) * 2, 1'b0);
    for (int n = 0; n < N_IDX; n++) drive_beat(2, n * 2, 1'b0);
    for (int n = 0; n < N_HAZ; n++) drive_beat(n % 3, (n % 4) * 2, 1'b1);
    repeat (3) @(posedge CLK);
    $display("Checker: %0d errors in %0d compares", err_count, check_count);
    if ((err_count == 0) && (check_count > 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #((N_BEATS + 20) * CLK_PERIOD);
    $display("Watchdog expired, the stimulus did not complete in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/vexec_pkg.sv
vector_lane/vector_lane.sv
execute/vexec_stage.sv
verilog/vexec_top.sv
verification/vexec_props.sv
verification/vexec_checker.sv
verification/vexec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module vexec_tb \
  -Mdir obj_dir -o vexec_sim

status=0
./obj_dir/vexec_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
